//--- include/bus_cfg.svh
/*
 * Register bus configuration
 * widths, firmware version and watchdog scaling shared by the bus core
 */

`ifndef BUS_CFG_SVH
`define BUS_CFG_SVH

// -----------------------------------------------
// bus widths
// -----------------------------------------------
`define BUS_ADDR_W     16              // quadlet address from either host
`define BUS_DATA_W     32              // one quadlet

// -----------------------------------------------
// board identity and memories
// -----------------------------------------------
`define FW_VERSION     32'h0000_0008   // returned by the version register
`define HUB_DEPTH      16              // quadlets in hub memory

// -----------------------------------------------
// watchdog
// -----------------------------------------------
`define WDOG_TICK      16              // sysclk cycles per period unit
`define WDOG_PERIOD_W  16              // period field width, 0 disables

`endif

//--- rtl/bus_addr_pkg.sv
/*
 * Address map types
 * region codes from address bits 15:12 and board register offsets
 * from address bits 3:0 of the main region
 */

package bus_addr_pkg;

    // -----------------------------------------------
    // regions, any code not listed is external
    // -----------------------------------------------
    typedef enum logic [3:0] {
        region_main = 4'd0,     // board registers
        region_hub  = 4'd1,     // hub quadlet memory
        region_prom = 4'd2,     // no logic here, reads zero
        region_eth  = 4'd4,     // no logic here, reads zero
        region_fw   = 4'd5      // no logic here, reads zero
    } region_t;

    // -----------------------------------------------
    // board registers inside the main region
    // -----------------------------------------------
    typedef enum logic [3:0] {
        reg_status  = 4'd0,     // board id and timeout flag
        reg_wdog    = 4'd3,     // watchdog period
        reg_version = 4'd4,     // firmware version, read only
        reg_ipaddr  = 4'd11     // ip address of this board
    } board_reg_t;

endpackage

//--- rtl/bus_ctrl_pkg.sv
/*
 * Arbiter control types
 * host identifiers and the arbiter FSM states
 */

package bus_ctrl_pkg;

    // which host owns the bus
    typedef enum logic {
        host_fw  = 1'b0,        // firewire host
        host_eth = 1'b1         // ethernet host, wins a tie
    } host_id_t;

    // arbiter sequence for one transaction
    typedef enum logic [1:0] {
        arb_idle = 2'd0,        // waiting for a request
        arb_exec = 2'd1,        // bus_start cycle
        arb_ack  = 2'd2         // ack held until req drops
    } arb_state_t;

endpackage

//--- rtl/host_arbiter.sv
/*
 * Host arbiter
 * grants the register bus to firewire or ethernet with ethernet priority,
 * muxes the granted host onto the bus and runs the four-phase ack
 */

`timescale 1ns/1ps
`include "bus_cfg.svh"

module host_arbiter
    import bus_ctrl_pkg::*;
(
    input  logic                   sysclk,
    input  logic                   rst_n,

    // firewire host
    input  logic                   fw_req,
    input  logic                   fw_we,
    input  logic [`BUS_ADDR_W-1:0] fw_addr,
    input  logic [`BUS_DATA_W-1:0] fw_wdata,
    output logic                   fw_ack,

    // ethernet host
    input  logic                   eth_req,
    input  logic                   eth_we,
    input  logic [`BUS_ADDR_W-1:0] eth_addr,
    input  logic [`BUS_DATA_W-1:0] eth_wdata,
    output logic                   eth_ack,

    // shared bus
    output logic                   bus_start,
    output logic                   bus_we,
    output logic [`BUS_ADDR_W-1:0] bus_addr,
    output logic [`BUS_DATA_W-1:0] bus_wdata
);

    arb_state_t state;          // arbiter FSM
    host_id_t   grant;          // owner of the current transaction
    logic       granted_req;    // req line of the owner

    assign granted_req = (grant == host_eth) ? eth_req : fw_req;

    // -----------------------------------------------
    // arbiter FSM
    // -----------------------------------------------
    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            state <= arb_idle;
            grant <= host_fw;
        end else begin
            case (state)
                arb_idle: begin
                    if (eth_req) begin          // eth first, as on the board
                        grant <= host_eth;
                        state <= arb_exec;
                    end else if (fw_req) begin
                        grant <= host_fw;
                        state <= arb_exec;
                    end
                end
                arb_exec: state <= arb_ack;     // write and read latch happen here
                arb_ack: begin
                    if (!granted_req)           // host released, close handshake
                        state <= arb_idle;
                end
                default: state <= arb_idle;
            endcase
        end
    end

    // -----------------------------------------------
    // bus mux and acks
    // -----------------------------------------------
    assign bus_start = (state == arb_exec);     // one cycle per transaction

    assign bus_we    = (grant == host_eth) ? eth_we    : fw_we;
    assign bus_addr  = (grant == host_eth) ? eth_addr  : fw_addr;
    assign bus_wdata = (grant == host_eth) ? eth_wdata : fw_wdata;

    assign fw_ack    = (state == arb_ack) && (grant == host_fw);
    assign eth_ack   = (state == arb_ack) && (grant == host_eth);

endmodule

//--- rtl/addr_decode.sv
/*
 * Address decode
 * splits the bus address into region and register offset and flags
 * board register hits and external (QLA) space
 */

`timescale 1ns/1ps
`include "bus_cfg.svh"

module addr_decode
    import bus_addr_pkg::*;
(
    input  logic [`BUS_ADDR_W-1:0] bus_addr,
    output region_t                region,
    output board_reg_t             reg_sel,
    output logic                   is_main,
    output logic                   is_ext
);

    logic known_region;         // region has logic inside this core
    logic board_hit;            // offset is a board register

    assign region  = region_t'(bus_addr[15:12]);
    assign reg_sel = board_reg_t'(bus_addr[3:0]);

    // main quadlets only when bits 7:4 are clear
    assign is_main = (region == region_main) && (bus_addr[7:4] == 4'd0);

    // -----------------------------------------------
    // region and register lookup
    // -----------------------------------------------
    always_comb begin
        case (region)
            region_main,
            region_hub,
            region_prom,
            region_eth,
            region_fw: known_region = 1'b1;
            default:   known_region = 1'b0;    // everything else goes to QLA
        endcase
    end

    always_comb begin
        case (reg_sel)
            reg_status,
            reg_wdog,
            reg_version,
            reg_ipaddr: board_hit = 1'b1;
            default:    board_hit = 1'b0;      // other offsets belong to QLA
        endcase
    end

    // -----------------------------------------------
    // external space
    // -----------------------------------------------
    // unknown regions, plus main addresses that miss the board registers
    assign is_ext = !known_region
                 || ((region == region_main) && !(is_main && board_hit));

endmodule

//--- rtl/board_regs.sv
/*
 * Board registers (execute stage)
 * ip address, watchdog period and timeout, hub memory and the
 * external write port, all written on bus_start
 */

`timescale 1ns/1ps
`include "bus_cfg.svh"

module board_regs
    import bus_addr_pkg::*;
(
    input  logic                      sysclk,
    input  logic                      rst_n,
    input  logic [3:0]                board_id,        // rotary switch

    // bus from the arbiter and decode
    input  logic                      bus_start,
    input  logic                      bus_we,
    input  logic [`BUS_ADDR_W-1:0]    bus_addr,
    input  logic [`BUS_DATA_W-1:0]    bus_wdata,
    input  region_t                   region,
    input  board_reg_t                reg_sel,
    input  logic                      is_main,
    input  logic                      is_ext,
    input  logic                      wdog_clear,      // e.g. on powerup

    // toward read_result
    output logic [`BUS_DATA_W-1:0]    status_word,
    output logic [`WDOG_PERIOD_W-1:0] wdog_period,
    output logic [`BUS_DATA_W-1:0]    ip_address,
    output logic [`BUS_DATA_W-1:0]    hub_rdata,

    // external (QLA) write port
    output logic                      ext_wen,
    output logic [`BUS_ADDR_W-1:0]    ext_waddr,
    output logic [`BUS_DATA_W-1:0]    ext_wdata,

    // watchdog
    output logic                      wdog_timeout,
    output logic                      wdog_period_led
);

    localparam int HUB_AW = $clog2(`HUB_DEPTH);
    localparam int CNT_W  = `WDOG_PERIOD_W + $clog2(`WDOG_TICK);

    logic [`BUS_DATA_W-1:0] hub_mem [0:`HUB_DEPTH-1];   // hub quadlets

    logic             wr_cyc;       // write transaction this cycle
    logic             wr_ip;
    logic             wr_wdog;
    logic             wr_hub;
    logic             wr_ext;
    logic [CNT_W-1:0] wdog_cnt;     // sysclk cycles since last transaction
    logic [CNT_W-1:0] wdog_limit;   // period in sysclk cycles
    logic             wdog_hit;

    // -----------------------------------------------
    // write decode
    // -----------------------------------------------
    assign wr_cyc  = bus_start && bus_we;
    assign wr_ip   = wr_cyc && is_main && (reg_sel == reg_ipaddr);
    assign wr_wdog = wr_cyc && is_main && (reg_sel == reg_wdog);
    assign wr_hub  = wr_cyc && (region == region_hub);
    assign wr_ext  = wr_cyc && is_ext;

    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            ip_address  <= '0;
            wdog_period <= '0;                  // watchdog off
            ext_wen     <= 1'b0;
        end else begin
            ext_wen <= wr_ext;                  // single-cycle strobe
            if (wr_ip)
                ip_address <= bus_wdata;
            if (wr_wdog)
                wdog_period <= bus_wdata[`WDOG_PERIOD_W-1:0];
        end
    end

    // hub memory and QLA write payload
    always_ff @(posedge sysclk) begin
        if (wr_hub)
            hub_mem[bus_addr[HUB_AW-1:0]] <= bus_wdata;
        if (wr_ext) begin
            ext_waddr <= bus_addr;
            ext_wdata <= bus_wdata;
        end
    end

    assign hub_rdata = hub_mem[bus_addr[HUB_AW-1:0]];  // async read, latched downstream

    // -----------------------------------------------
    // watchdog
    // -----------------------------------------------
    assign wdog_limit = CNT_W'(wdog_period) * CNT_W'(`WDOG_TICK);
    assign wdog_hit   = (wdog_period != '0) && (wdog_cnt == wdog_limit);

    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            wdog_cnt     <= '0;
            wdog_timeout <= 1'b0;
        end else begin
            if (bus_start || wdog_clear)        // any host access restarts
                wdog_cnt <= '0;
            else if ((wdog_period != '0) && !wdog_hit)
                wdog_cnt <= wdog_cnt + 1'b1;    // holds at the limit

            if (wr_wdog || wdog_clear)
                wdog_timeout <= 1'b0;
            else if (wdog_hit)
                wdog_timeout <= 1'b1;           // sticky until cleared
        end
    end

    assign wdog_period_led = (wdog_period != '0);

    // status: board id in 27:24, timeout in bit 0
    always_comb begin
        status_word        = '0;
        status_word[27:24] = board_id;
        status_word[0]     = wdog_timeout;
    end

endmodule

//--- rtl/read_result.sv
/*
 * Read result
 * selects read data by region and register and latches it on
 * bus_start so it stays valid while the host sees its ack
 */

`timescale 1ns/1ps
`include "bus_cfg.svh"

module read_result
    import bus_addr_pkg::*;
(
    input  logic                      sysclk,
    input  logic                      rst_n,
    input  logic                      bus_start,
    input  region_t                   region,
    input  board_reg_t                reg_sel,
    input  logic                      is_main,
    input  logic                      is_ext,

    // sources
    input  logic [`BUS_DATA_W-1:0]    status_word,
    input  logic [`WDOG_PERIOD_W-1:0] wdog_period,
    input  logic [`BUS_DATA_W-1:0]    ip_address,
    input  logic [`BUS_DATA_W-1:0]    hub_rdata,
    input  logic [`BUS_DATA_W-1:0]    ext_rdata,       // from QLA board

    output logic [`BUS_DATA_W-1:0]    rd_data
);

    logic [`BUS_DATA_W-1:0] rd_next;    // mux output before the latch

    // -----------------------------------------------
    // read mux
    // -----------------------------------------------
    always_comb begin
        rd_next = '0;                   // prom, eth and fw regions read zero
        if (is_ext) begin
            rd_next = ext_rdata;
        end else if (region == region_hub) begin
            rd_next = hub_rdata;
        end else if (is_main) begin
            case (reg_sel)
                reg_status:  rd_next = status_word;
                reg_wdog:    rd_next[`WDOG_PERIOD_W-1:0] = wdog_period;
                reg_version: rd_next = `FW_VERSION;
                reg_ipaddr:  rd_next = ip_address;
                default:     rd_next = '0;
            endcase
        end
    end

    // held from bus_start to the next one
    always_ff @(posedge sysclk) begin
        if (!rst_n)
            rd_data <= '0;
        else if (bus_start)
            rd_data <= rd_next;
    end

endmodule

//--- rtl/fpga_bus_core.sv
/*
 * FPGA register bus core
 * arbiter, address decode, board registers and read result for
 * the firewire and ethernet hosts of the motor controller
 */

`timescale 1ns/1ps
`include "bus_cfg.svh"

module fpga_bus_core
    import bus_addr_pkg::*;
(
    input  logic                   sysclk,
    input  logic                   rst_n,
    input  logic [3:0]             board_id,

    input  logic                   fw_req,
    input  logic                   fw_we,
    input  logic [`BUS_ADDR_W-1:0] fw_addr,
    input  logic [`BUS_DATA_W-1:0] fw_wdata,
    output logic                   fw_ack,

    input  logic                   eth_req,
    input  logic                   eth_we,
    input  logic [`BUS_ADDR_W-1:0] eth_addr,
    input  logic [`BUS_DATA_W-1:0] eth_wdata,
    output logic                   eth_ack,

    output logic [`BUS_DATA_W-1:0] rd_data,         // valid while an ack is high

    input  logic [`BUS_DATA_W-1:0] ext_rdata,       // QLA read data
    output logic                   ext_wen,
    output logic [`BUS_ADDR_W-1:0] ext_waddr,
    output logic [`BUS_DATA_W-1:0] ext_wdata,

    input  logic                   wdog_clear,
    output logic                   wdog_timeout,
    output logic                   wdog_period_led
);

    // -----------------------------------------------
    // internal bus
    // -----------------------------------------------
    logic                      bus_start;
    logic                      bus_we;
    logic [`BUS_ADDR_W-1:0]    bus_addr;
    logic [`BUS_DATA_W-1:0]    bus_wdata;
    region_t                   region;
    board_reg_t                reg_sel;
    logic                      is_main;
    logic                      is_ext;
    logic [`BUS_DATA_W-1:0]    status_word;
    logic [`WDOG_PERIOD_W-1:0] wdog_period;
    logic [`BUS_DATA_W-1:0]    ip_address;
    logic [`BUS_DATA_W-1:0]    hub_rdata;

    host_arbiter u_arb (
        .sysclk, .rst_n,
        .fw_req, .fw_we, .fw_addr, .fw_wdata, .fw_ack,
        .eth_req, .eth_we, .eth_addr, .eth_wdata, .eth_ack,
        .bus_start, .bus_we, .bus_addr, .bus_wdata
    );

    addr_decode u_decode (
        .bus_addr, .region, .reg_sel, .is_main, .is_ext
    );

    board_regs u_exec (
        .sysclk, .rst_n, .board_id,
        .bus_start, .bus_we, .bus_addr, .bus_wdata,
        .region, .reg_sel, .is_main, .is_ext, .wdog_clear,
        .status_word, .wdog_period, .ip_address, .hub_rdata,
        .ext_wen, .ext_waddr, .ext_wdata,
        .wdog_timeout, .wdog_period_led
    );

    read_result u_result (
        .sysclk, .rst_n, .bus_start,
        .region, .reg_sel, .is_main, .is_ext,
        .status_word, .wdog_period, .ip_address, .hub_rdata, .ext_rdata,
        .rd_data
    );

endmodule

//--- testbench/fpga_bus_core_assert.sv
/*
 * Handshake assertions for the register bus core
 * four-phase ack rules for the firewire and ethernet hosts
 */

`timescale 1ns/1ps

module fpga_bus_core_assert (
    input logic sysclk,
    input logic rst_n,
    input logic fw_req,
    input logic fw_ack,
    input logic eth_req,
    input logic eth_ack
);

    int unsigned fail_count = 0;    // assertion failures so far

    // -----------------------------------------------
    // ack rules
    // -----------------------------------------------
    a_one_owner: assert property (@(posedge sysclk) disable iff (!rst_n)
        !(fw_ack && eth_ack))
        else begin
            fail_count++;
            $error("fw_ack and eth_ack high together");
        end

    // req is dropped right after ack is seen, so look one sample back
    a_fw_rise: assert property (@(posedge sysclk) disable iff (!rst_n)
        $rose(fw_ack) |-> $past(fw_req))
        else begin
            fail_count++;
            $error("fw_ack rose without fw_req");
        end

    a_eth_rise: assert property (@(posedge sysclk) disable iff (!rst_n)
        $rose(eth_ack) |-> $past(eth_req))
        else begin
            fail_count++;
            $error("eth_ack rose without eth_req");
        end

    // ack may only fall once req was seen low the sample before
    a_fw_hold: assert property (@(posedge sysclk) disable iff (!rst_n)
        $fell(fw_ack) |-> !$past(fw_req))
        else begin
            fail_count++;
            $error("fw_ack dropped while fw_req still high");
        end

    a_eth_hold: assert property (@(posedge sysclk) disable iff (!rst_n)
        $fell(eth_ack) |-> !$past(eth_req))
        else begin
            fail_count++;
            $error("eth_ack dropped while eth_req still high");
        end

    a_reset_idle: assert property (@(posedge sysclk)
        $rose(rst_n) |-> (!fw_ack && !eth_ack))
        else begin
            fail_count++;
            $error("ack high right after reset release");
        end

endmodule

bind fpga_bus_core fpga_bus_core_assert u_assert (.*);

//--- testbench/tb_fpga_bus_core.sv
/*
 * Testbench for the register bus core
 * runs a table of host transactions through both host ports, then
 * checks external writes, ethernet priority and the watchdog
 */

`timescale 1ns/1ps
`include "bus_cfg.svh"

module tb_fpga_bus_core
    import bus_ctrl_pkg::*;
();

    localparam int                     MAX_WAIT = 200;         // cycles per wait
    localparam logic [3:0]             BOARD_ID = 4'hA;
    localparam logic [`BUS_DATA_W-1:0] EXT_RD   = 32'h5A5A_1234;  // QLA read value
    localparam logic [`BUS_DATA_W-1:0] IP_VAL   = 32'hC0A8_0A05;

    typedef struct packed {
        host_id_t               host;
        logic                   we;
        logic [`BUS_ADDR_W-1:0] addr;
        logic [`BUS_DATA_W-1:0] wdata;
        logic                   chk;    // compare rd_data at ack
        logic [`BUS_DATA_W-1:0] exp;
    } step_t;

    logic                   sysclk;
    logic                   rst_n;
    logic [3:0]             board_id;
    logic                   fw_req, fw_we, fw_ack;
    logic [`BUS_ADDR_W-1:0] fw_addr;
    logic [`BUS_DATA_W-1:0] fw_wdata;
    logic                   eth_req, eth_we, eth_ack;
    logic [`BUS_ADDR_W-1:0] eth_addr;
    logic [`BUS_DATA_W-1:0] eth_wdata;
    logic [`BUS_DATA_W-1:0] rd_data, ext_rdata, ext_wdata;
    logic [`BUS_ADDR_W-1:0] ext_waddr;
    logic                   ext_wen, wdog_clear, wdog_timeout, wdog_period_led;

    step_t                  steps [0:63];
    int                     n_steps = 0;
    integer                 seed;
    int                     ext_wen_cnt = 0;    // ext_wen pulses seen
    logic [`BUS_ADDR_W-1:0] ext_waddr_seen;
    logic [`BUS_DATA_W-1:0] ext_wdata_seen;

    fpga_bus_core u_dut (.*);

    initial begin
        sysclk = 1'b0;
        forever #2 sysclk = ~sysclk;
    end

    always @(posedge sysclk) begin
        if (rst_n && ext_wen) begin
            ext_wen_cnt    <= ext_wen_cnt + 1;
            ext_waddr_seen <= ext_waddr;
            ext_wdata_seen <= ext_wdata;
        end
    end

    // -----------------------------------------------
    // reporting and checks
    // -----------------------------------------------
    task automatic abort_run(input string what);
        $display("%s", what);
        $display("sim failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_data(input string name, input logic [`BUS_DATA_W-1:0] exp,
                              input logic [`BUS_DATA_W-1:0] act);
        if (act !== exp)
            abort_run($sformatf("Mismatch %s expected %h actual %h", name, exp, act));
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp)
            abort_run($sformatf("Mismatch %s expected %b actual %b", name, exp, act));
    endtask

    function automatic void add_step(input host_id_t host, input logic we,
                                     input logic [`BUS_ADDR_W-1:0] addr,
                                     input logic [`BUS_DATA_W-1:0] wdata,
                                     input logic chk, input logic [`BUS_DATA_W-1:0] exp);
        steps[n_steps] = '{host, we, addr, wdata, chk, exp};
        n_steps++;
    endfunction

    // -----------------------------------------------
    // host side of the four-phase handshake
    // -----------------------------------------------
    task automatic wait_ack(input host_id_t host, input logic level, output time seen);
        int n;
        n = 0;
        while (((host == host_eth) ? eth_ack : fw_ack) !== level) begin
            if (n == MAX_WAIT)
                abort_run($sformatf("timed out waiting for %s ack to go %b",
                                    (host == host_eth) ? "eth" : "fw", level));
            @(posedge sysclk);
            #1;
            n++;
        end
        seen = $time;
    endtask

    task automatic host_txn(input host_id_t host, input logic we,
                            input logic [`BUS_ADDR_W-1:0] addr,
                            input logic [`BUS_DATA_W-1:0] wdata,
                            output logic [`BUS_DATA_W-1:0] rdata, output time ack_time);
        time t_low;
        @(posedge sysclk);
        #1;
        if (host == host_eth) begin
            eth_we    = we;
            eth_addr  = addr;
            eth_wdata = wdata;
            eth_req   = 1'b1;
        end else begin
            fw_we     = we;
            fw_addr   = addr;
            fw_wdata  = wdata;
            fw_req    = 1'b1;
        end
        wait_ack(host, 1'b1, ack_time);
        rdata = rd_data;                        // held while ack is high
        if (host == host_eth)
            eth_req = 1'b0;
        else
            fw_req = 1'b0;
        wait_ack(host, 1'b0, t_low);
    endtask

    task automatic wait_wdog_timeout();
        int n;
        n = 0;
        while (wdog_timeout !== 1'b1) begin
            if (n == MAX_WAIT)
                abort_run("watchdog timeout flag never rose");
            @(posedge sysclk);
            #1;
            n++;
        end
    endtask

    // -----------------------------------------------
    // main sequence
    // -----------------------------------------------
    initial begin
        step_t                  st;
        logic [`BUS_DATA_W-1:0] rdata, fw_rd, eth_rd;
        logic [`BUS_DATA_W-1:0] hub_vals [0:15];
        time                    t_fw, t_eth, t_unused;

        seed      = 32'h7b91;
        rst_n     = 1'b0;
        board_id  = BOARD_ID;
        fw_req    = 1'b0;
        fw_we     = 1'b0;
        fw_addr   = '0;
        fw_wdata  = '0;
        eth_req   = 1'b0;
        eth_we    = 1'b0;
        eth_addr  = '0;
        eth_wdata = '0;
        ext_rdata = EXT_RD;
        wdog_clear = 1'b0;

        // board registers, ip written by fw and read by eth
        add_step(host_fw,  1'b1, 16'h000B, IP_VAL, 1'b0, '0);
        add_step(host_eth, 1'b0, 16'h000B, '0, 1'b1, IP_VAL);
        add_step(host_fw,  1'b0, 16'h0004, '0, 1'b1, `FW_VERSION);
        add_step(host_eth, 1'b0, 16'h0000, '0, 1'b1, {4'h0, BOARD_ID, 24'h0});
        for (int i = 0; i < 16; i++) begin
            hub_vals[i] = $random(seed);
            add_step(host_fw, 1'b1, {12'h100, 4'(i)}, hub_vals[i], 1'b0, '0);
        end
        for (int i = 0; i < 16; i++)
            add_step(host_eth, 1'b0, {12'h100, 4'(i)}, '0, 1'b1, hub_vals[i]);
        add_step(host_fw,  1'b0, 16'h2000, '0, 1'b1, '0);     // prom
        add_step(host_eth, 1'b0, 16'h4000, '0, 1'b1, '0);     // eth
        add_step(host_fw,  1'b0, 16'h5000, '0, 1'b1, '0);     // fw
        add_step(host_eth, 1'b1, 16'h7123, 32'hDEAD_0001, 1'b0, '0);
        add_step(host_fw,  1'b0, 16'h8010, '0, 1'b1, EXT_RD);
        add_step(host_eth, 1'b0, 16'h0001, '0, 1'b1, EXT_RD);  // main offset, not a board reg

        repeat (3) @(posedge sysclk);
        #1;
        rst_n = 1'b1;
        check_bit("wdog_timeout after reset", 1'b0, wdog_timeout);

        for (int i = 0; i < n_steps; i++) begin
            st = steps[i];
            host_txn(st.host, st.we, st.addr, st.wdata, rdata, t_unused);
            if (st.chk)
                check_data($sformatf("step %0d addr %h", i, st.addr), st.exp, rdata);
        end

        // one external write in the whole table
        check_data("ext_wen pulses", 32'd1, 32'(ext_wen_cnt));
        check_data("ext_waddr", {16'h0, 16'h7123}, {16'h0, ext_waddr_seen});
        check_data("ext_wdata", 32'hDEAD_0001, ext_wdata_seen);

        // both hosts in the same cycle, eth must go first
        fork
            host_txn(host_fw,  1'b0, 16'h000B, '0, fw_rd, t_fw);
            host_txn(host_eth, 1'b0, 16'h0004, '0, eth_rd, t_eth);
        join
        check_bit("eth ack before fw ack", 1'b1, t_eth < t_fw);
        check_data("priority fw read", IP_VAL, fw_rd);
        check_data("priority eth read", `FW_VERSION, eth_rd);

        // watchdog, period 2
        host_txn(host_fw, 1'b1, 16'h0003, 32'd2, rdata, t_unused);
        wait_wdog_timeout();
        check_bit("wdog_period_led on", 1'b1, wdog_period_led);
        host_txn(host_fw, 1'b0, 16'h0003, '0, rdata, t_unused);
        check_data("wdog period read", 32'd2, rdata);
        host_txn(host_eth, 1'b0, 16'h0000, '0, rdata, t_unused);
        check_data("status with timeout", {4'h0, BOARD_ID, 23'h0, 1'b1}, rdata);
        @(posedge sysclk);
        #1;
        wdog_clear = 1'b1;
        @(posedge sysclk);
        #1;
        wdog_clear = 1'b0;
        check_bit("wdog_timeout after clear", 1'b0, wdog_timeout);

        // period 0 turns the watchdog off
        host_txn(host_fw, 1'b1, 16'h0003, 32'd0, rdata, t_unused);
        check_bit("wdog_period_led off", 1'b0, wdog_period_led);
        repeat (300) begin
            @(posedge sysclk);
            #1;
            check_bit("wdog_timeout with period 0", 1'b0, wdog_timeout);
        end

        if (u_dut.u_assert.fail_count == 0) begin
            $display("sim passed");
            $finish;
        end else begin
            $display("handshake assertions failed %0d times", u_dut.u_assert.fail_count);
            $display("sim failed");
            $fatal(1, "assertion failures");
        end
    end

endmodule

//--- sim.f
+incdir+include
rtl/bus_addr_pkg.sv
rtl/bus_ctrl_pkg.sv
rtl/host_arbiter.sv
rtl/addr_decode.sv
rtl/board_regs.sv
rtl/read_result.sv
rtl/fpga_bus_core.sv
testbench/fpga_bus_core_assert.sv
testbench/tb_fpga_bus_core.sv

//--- run_sim.sh
#!/bin/sh
# build and run the bus core testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -f sim.log

verilator --binary --timing --assert -j 0 \
    --top-module tb_fpga_bus_core -f sim.f -o tb_sim

./obj_dir/tb_sim | tee sim.log

if grep -q "sim passed" sim.log; then
    echo "PASS"
else
    echo "FAIL"
    exit 1
fi
